//--- Bender.yml
package:
  name: axi_trace_encoder

dependencies: {}

sources:
  # package first, then the blocks, then the top level
  - logic/trace_pkg.sv
  - logic/axi_link_tap.sv
  - logic/trace_formatter.sv
  - logic/trace_packer.sv
  - logic/axi_trace_encoder.sv

  - target: test
    files:
      - bench/tb_axi_trace_encoder.sv

//--- bench/tb_axi_trace_encoder.sv
`timescale 1ns/100ps

module tb_axi_trace_encoder;
    import trace_pkg::*;

    localparam int BEAT_WIDTH = 128;
    localparam int NUM_BEATS  = (TRACE_PKG_WIDTH + BEAT_WIDTH - 1) / BEAT_WIDTH;
    localparam int FLAT_W     = NUM_BEATS * BEAT_WIDTH;
    localparam int MAX_CYCLES = 2000;  // six tests of at most about 250 cycles plus a margin

    logic                  clk;
    logic                  rst_n;
    axi_a_chan_t           m_ar, m_aw, s_ar, s_aw;
    axi_w_chan_t           m_w, s_w;
    axi_r_chan_t           m_r, s_r;
    axi_b_chan_t           m_b, s_b;
    logic                  m_arvalid, m_awvalid, m_wvalid, m_rvalid, m_bvalid;
    logic                  m_arready, m_awready, m_wready, m_rready, m_bready;
    logic                  s_arvalid, s_awvalid, s_wvalid, s_rvalid, s_bvalid;
    logic                  s_arready, s_awready, s_wready, s_rready, s_bready;
    logic [BEAT_WIDTH-1:0] out_data;
    logic                  out_valid, out_ready, out_last;

    // reference model of the trace stream
    logic [NUM_BEATS-1:0][BEAT_WIDTH-1:0] exp_beats;  // expected package, top beat leaves first
    int                    exp_left;                  // beats still owed, zero means link open
    logic [BEAT_WIDTH-1:0] exp_beat;
    timestamp_t            ts_model;
    trace_seq_t            seq_model;
    chan_mask_t            port_fire;                 // handshakes as the master side sees them
    logic [FLAT_W-1:0]     rx_flat;                   // beats collected from the stream
    trace_seq_t            rx_seq_next = '0;
    timestamp_t            rx_last_ts;
    int                    err_cnt = 0;
    int                    pkg_cnt = 0;
    int                    beat_cnt = 0;
    int                    cycle_cnt = 0;
    int                    offered[5] = '{default: 0};
    int                    completed[5] = '{default: 0};
    logic [31:0]           rng_state;
    logic                  rand_ready;                // receivers drop ready at random
    logic                  rand_stall;                // trace consumer stalls at random
    string                 cur_test;

    axi_trace_encoder #(.BEAT_WIDTH(BEAT_WIDTH)) u_axi_trace_encoder (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ########################################
    // helpers
    // ########################################
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic chan_mask_t random_mask();
        logic [31:0] r;
        r = next_rand();
        return (r[4:0] == '0) ? 5'b00100 : r[4:0];  // an empty mask would send nothing
    endfunction

    // header, then ar, aw, r, w, b records, each payload zero filled above its low bits
    function automatic logic [FLAT_W-1:0] build_expected(input chan_mask_t f);
        logic [63:0] ar_rec;
        logic [63:0] aw_rec;
        logic [63:0] r_rec;
        logic [63:0] w_rec;
        logic [15:0] b_rec;
        ar_rec = f[4] ? {11'b0, m_ar} : 64'b0;
        aw_rec = f[3] ? {11'b0, m_aw} : 64'b0;
        r_rec  = f[2] ? {21'b0, s_r} : 64'b0;
        w_rec  = f[1] ? {27'b0, m_w} : 64'b0;
        b_rec  = f[0] ? {6'b0, s_b} : 16'b0;
        return {{(FLAT_W - TRACE_PKG_WIDTH){1'b0}}, ts_model, seq_model, f, 3'b000,
                ar_rec, aw_rec, r_rec, w_rec, b_rec};
    endfunction

    task automatic value_error(input string what, input logic [511:0] expv,
                               input logic [511:0] actv);
        err_cnt++;
        $display("FAILED %s %s: expected %0h actual %0h", cur_test, what, expv, actv);
    endtask

    task automatic plain_error(input string msg);
        err_cnt++;
        $display("error in test %s: %s", cur_test, msg);
    endtask

    // offers one transfer on each channel in the mask and holds it until it is taken
    task automatic transfer(input chan_mask_t mask);
        logic [63:0] r;
        chan_mask_t  pend;
        int          waited;
        r = {next_rand(), next_rand()};
        m_ar = r[52:0];
        r = {next_rand(), next_rand()};
        m_aw = r[52:0];
        s_b = r[63:54];
        r = {next_rand(), next_rand()};
        m_w = r[36:0];
        r = {next_rand(), next_rand()};
        s_r = r[42:0];
        pend = mask;
        waited = 0;
        for (int i = 0; i < 5; i++) offered[i] += mask[i];
        {m_arvalid, m_awvalid, s_rvalid, m_wvalid, s_bvalid} = pend;
        while (pend != '0 && waited < 200) begin
            @(posedge clk);
            pend = pend & ~port_fire;  // each channel lets go once its own handshake is seen
            waited++;
            #1;
            {m_arvalid, m_awvalid, s_rvalid, m_wvalid, s_bvalid} = pend;
        end
        if (pend != '0) plain_error("a transfer offered by the master never completed");
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_left != 0 && waited < 300) begin
            @(posedge clk);
            waited++;
        end
        #1;
        if (exp_left != 0) plain_error("the trace stream never finished its package");
    endtask

    // ########################################
    // reference model and receive side
    // ########################################
    assign port_fire = {m_arvalid & m_arready, m_awvalid & m_awready, m_rvalid & m_rready,
                        m_wvalid & m_wready, m_bvalid & m_bready};
    assign exp_beat  = (exp_left > 0) ? exp_beats[exp_left - 1] : '0;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ts_model  <= '0;
            seq_model <= '0;
            exp_left  <= 0;
        end else begin
            ts_model <= ts_model + 1'b1;
            if (out_valid && out_ready && exp_left > 0) exp_left <= exp_left - 1;
            if (|port_fire) begin
                exp_beats <= build_expected(port_fire);
                exp_left  <= NUM_BEATS;
                seq_model <= seq_model + 1'b1;  // header keeps the value from before this step
            end
            for (int i = 0; i < 5; i++) completed[i] += port_fire[i];
        end
    end

    // rebuilds each package from the stream and checks seq and timestamp across packages
    always @(posedge clk) begin : collect_beats
        logic [FLAT_W-1:0] full;
        trace_header_t     hdr;
        if (rst_n && out_valid && out_ready) begin
            full = (rx_flat << BEAT_WIDTH) | out_data;
            rx_flat = full;
            beat_cnt++;
            if (out_last) begin
                hdr = full[TRACE_PKG_WIDTH-1 -: $bits(trace_header_t)];
                assert (hdr.seq == rx_seq_next)
                    else value_error("header seq", rx_seq_next, hdr.seq);
                assert (pkg_cnt == 0 || hdr.timestamp > rx_last_ts)
                    else plain_error("timestamp did not increase between packages");
                rx_seq_next = hdr.seq + 1'b1;
                rx_last_ts = hdr.timestamp;
                pkg_cnt++;
            end
        end
    end

    // receivers and the trace consumer draw at the edge and move 1 ns after it
    always @(posedge clk) begin : drive_readies
        logic [31:0] r;
        r = next_rand();
        #1;
        {s_arready, s_awready, s_wready, m_rready, m_bready} = rand_ready ? (r[4:0] | r[9:5])
                                                                          : 5'h1f;
        out_ready = rand_stall ? (r[10] | r[11]) : 1'b1;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    // ########################################
    // checks
    // ########################################
    a_open_pass_through: assert property (@(posedge clk) disable iff (!rst_n)
        exp_left == 0 |-> s_ar == m_ar && s_aw == m_aw && s_w == m_w && m_r == s_r
            && m_b == s_b && s_arvalid == m_arvalid && s_awvalid == m_awvalid
            && s_wvalid == m_wvalid && m_rvalid == s_rvalid && m_bvalid == s_bvalid
            && m_arready == s_arready && m_awready == s_awready && m_wready == s_wready
            && s_rready == m_rready && s_bready == m_bready)
        else plain_error("slave side differs from master side while the link is open");

    a_closed_link: assert property (@(posedge clk) disable iff (!rst_n)
        exp_left != 0 |-> !(m_arready | m_awready | m_wready | s_rready | s_bready
            | s_arvalid | s_awvalid | s_wvalid | m_rvalid | m_bvalid))
        else plain_error("the link passed a handshake while a package was leaving");

    a_valid_matches: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == (exp_left != 0))
        else value_error("out_valid", $sampled(exp_left != 0), $sampled(out_valid));

    a_last_final: assert property (@(posedge clk) disable iff (!rst_n)
        out_last == (exp_left == 1))
        else value_error("out_last", $sampled(exp_left == 1), $sampled(out_last));

    a_beat_data: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_data == exp_beat)
        else value_error("beat data", $sampled(exp_beat), $sampled(out_data));

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data) && $stable(out_last))
        else plain_error("a stalled trace beat changed before it was taken");

    // ########################################
    // stimulus
    // ########################################
    initial begin
        rng_state = 32'd92;
        rst_n = 1'b0;
        rand_ready = 1'b0;
        rand_stall = 1'b0;
        out_ready = 1'b1;
        {s_arready, s_awready, s_wready, m_rready, m_bready} = '1;
        {m_arvalid, m_awvalid, s_rvalid, m_wvalid, s_bvalid} = '0;
        m_ar = '0;
        m_aw = '0;
        m_w = '0;
        s_r = '0;
        s_b = '0;
        rx_flat = '0;
        rx_last_ts = '0;
        cur_test = "reset";
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        cur_test = "pass_through";
        rand_ready = 1'b1;
        repeat (8) transfer(random_mask());
        wait_idle();
        rand_ready = 1'b0;
        cur_test = "lone_aw";
        transfer(5'b01000);
        wait_idle();
        cur_test = "ar_w_b";
        transfer(5'b10011);
        wait_idle();
        cur_test = "gate_hold";
        rand_stall = 1'b1;
        transfer(5'b01000);
        transfer(5'b10100);  // offered while the aw package is still leaving
        wait_idle();
        cur_test = "stalls";
        repeat (6) transfer(random_mask());
        wait_idle();
        rand_stall = 1'b0;
        cur_test = "sequence";
        repeat (8) transfer(random_mask());
        wait_idle();
        repeat (2) @(posedge clk);
        cur_test = "completion";
        for (int i = 0; i < 5; i++) begin
            if (offered[i] != completed[i]) plain_error("offered and completed transfers differ");
        end
        $display("summary: %0d packages, %0d beats, %0d errors", pkg_cnt, beat_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- logic/axi_link_tap.sv
`timescale 1ns/100ps

module axi_link_tap (
    input  logic                   clk,        // only the checks below use the clock
    input  logic                   rst_n,
    // master side, the tap looks like a slave here
    input  trace_pkg::axi_a_chan_t m_ar,
    input  logic                   m_arvalid,
    output logic                   m_arready,
    input  trace_pkg::axi_a_chan_t m_aw,
    input  logic                   m_awvalid,
    output logic                   m_awready,
    input  trace_pkg::axi_w_chan_t m_w,
    input  logic                   m_wvalid,
    output logic                   m_wready,
    output trace_pkg::axi_r_chan_t m_r,
    output logic                   m_rvalid,
    input  logic                   m_rready,
    output trace_pkg::axi_b_chan_t m_b,
    output logic                   m_bvalid,
    input  logic                   m_bready,
    // slave side, the tap looks like a master here
    output trace_pkg::axi_a_chan_t s_ar,
    output logic                   s_arvalid,
    input  logic                   s_arready,
    output trace_pkg::axi_a_chan_t s_aw,
    output logic                   s_awvalid,
    input  logic                   s_awready,
    output trace_pkg::axi_w_chan_t s_w,
    output logic                   s_wvalid,
    input  logic                   s_wready,
    input  trace_pkg::axi_r_chan_t s_r,
    input  logic                   s_rvalid,
    output logic                   s_rready,
    input  trace_pkg::axi_b_chan_t s_b,
    input  logic                   s_bvalid,
    output logic                   s_bready,
    // toward the formatter and packer
    input  logic                   gate_open,  // low while a package is still leaving
    output trace_pkg::chan_mask_t  fire,
    output trace_pkg::axi_a_chan_t ar_pl,
    output trace_pkg::axi_a_chan_t aw_pl,
    output trace_pkg::axi_w_chan_t w_pl,
    output trace_pkg::axi_r_chan_t r_pl,
    output trace_pkg::axi_b_chan_t b_pl
);
    import trace_pkg::*;

    // ####################################
    // request channels run master to slave
    // ####################################
    assign s_ar      = m_ar;
    assign s_arvalid = m_arvalid & gate_open;  // the slave never sees a request while closed
    assign m_arready = s_arready & gate_open;  // and the master never sees it taken
    assign s_aw      = m_aw;
    assign s_awvalid = m_awvalid & gate_open;
    assign m_awready = s_awready & gate_open;
    assign s_w       = m_w;
    assign s_wvalid  = m_wvalid & gate_open;
    assign m_wready  = s_wready & gate_open;

    // response channels run the other way, so the gating mirrors
    assign m_r       = s_r;
    assign m_rvalid  = s_rvalid & gate_open;
    assign s_rready  = m_rready & gate_open;
    assign m_b       = s_b;
    assign m_bvalid  = s_bvalid & gate_open;
    assign s_bready  = m_bready & gate_open;

    // a channel fires on its gated handshake, which both ends agree on
    always_comb begin
        fire[CH_AR] = s_arvalid & s_arready;
        fire[CH_AW] = s_awvalid & s_awready;
        fire[CH_R]  = m_rvalid & m_rready;
        fire[CH_W]  = s_wvalid & s_wready;
        fire[CH_B]  = m_bvalid & m_bready;
    end

    // each record is taken from whoever drives that channel
    assign ar_pl = m_ar;
    assign aw_pl = m_aw;
    assign w_pl  = m_w;
    assign r_pl  = s_r;
    assign b_pl  = s_b;

    // a transfer that completes while the packer is busy would be lost from the trace
    a_no_fire_closed: assert property (@(posedge clk) disable iff (!rst_n)
        !gate_open |-> fire == '0)
        else $error("transfer completed while the link was closed");

endmodule

//--- logic/axi_trace_encoder.sv
`timescale 1ns/100ps

module axi_trace_encoder #(
    parameter int BEAT_WIDTH = 128  // 256 and 512 fit as well
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // ####################################
    // master side
    // ####################################
    input  trace_pkg::axi_a_chan_t m_ar,
    input  logic                   m_arvalid,
    output logic                   m_arready,
    input  trace_pkg::axi_a_chan_t m_aw,
    input  logic                   m_awvalid,
    output logic                   m_awready,
    input  trace_pkg::axi_w_chan_t m_w,
    input  logic                   m_wvalid,
    output logic                   m_wready,
    output trace_pkg::axi_r_chan_t m_r,
    output logic                   m_rvalid,
    input  logic                   m_rready,
    output trace_pkg::axi_b_chan_t m_b,
    output logic                   m_bvalid,
    input  logic                   m_bready,
    // ####################################
    // slave side
    // ####################################
    output trace_pkg::axi_a_chan_t s_ar,
    output logic                   s_arvalid,
    input  logic                   s_arready,
    output trace_pkg::axi_a_chan_t s_aw,
    output logic                   s_awvalid,
    input  logic                   s_awready,
    output trace_pkg::axi_w_chan_t s_w,
    output logic                   s_wvalid,
    input  logic                   s_wready,
    input  trace_pkg::axi_r_chan_t s_r,
    input  logic                   s_rvalid,
    output logic                   s_rready,
    input  trace_pkg::axi_b_chan_t s_b,
    input  logic                   s_bvalid,
    output logic                   s_bready,
    // trace stream, most significant beat first
    output logic [BEAT_WIDTH-1:0]  out_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic                   out_last
);
    import trace_pkg::*;

    logic           gate_open;  // packer lets the link run
    chan_mask_t     fire;       // channels completing a transfer this cycle
    axi_a_chan_t    ar_pl;
    axi_a_chan_t    aw_pl;
    axi_w_chan_t    w_pl;
    axi_r_chan_t    r_pl;
    axi_b_chan_t    b_pl;
    trace_package_t pkg;        // built combinationally in the fire cycle

    // the tap ports share their names with the top level and the wires above
    axi_link_tap u_tap (.*);

    trace_formatter u_fmt (
        .clk   (clk),
        .rst_n (rst_n),
        .fire  (fire),
        .ar_pl (ar_pl),
        .aw_pl (aw_pl),
        .w_pl  (w_pl),
        .r_pl  (r_pl),
        .b_pl  (b_pl),
        .pkg   (pkg)
    );

    trace_packer #(
        .BEAT_WIDTH (BEAT_WIDTH)
    ) u_pack (
        .clk       (clk),
        .rst_n     (rst_n),
        .fire      (fire),
        .pkg       (pkg),
        .gate_open (gate_open),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

endmodule

//--- logic/trace_formatter.sv
`timescale 1ns/100ps

module trace_formatter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  trace_pkg::chan_mask_t     fire,   // channels whose transfer completes this cycle
    input  trace_pkg::axi_a_chan_t    ar_pl,
    input  trace_pkg::axi_a_chan_t    aw_pl,
    input  trace_pkg::axi_w_chan_t    w_pl,
    input  trace_pkg::axi_r_chan_t    r_pl,
    input  trace_pkg::axi_b_chan_t    b_pl,
    output trace_pkg::trace_package_t pkg     // valid in every cycle where fire is non-zero
);
    import trace_pkg::*;

    timestamp_t ts_q;   // counts every cycle since reset
    trace_seq_t seq_q;  // number of packages already handed to the packer

    // ####################################
    // header counters
    // ####################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ts_q  <= '0;
            seq_q <= '0;
        end else begin
            ts_q <= ts_q + 1'b1;
            // the packer takes every fire cycle, so each one is a package
            if (|fire) begin
                seq_q <= seq_q + 1'b1;
            end
        end
    end

    // ####################################
    // package assembly
    // ####################################
    always_comb begin
        pkg = '0;  // records of quiet channels stay zero

        // the header shows the count before this package bumps it
        pkg.header.timestamp = ts_q;
        pkg.header.seq       = seq_q;
        pkg.header.mask      = fire;

        // the casts widen with zeros, which right aligns the payload in its record
        if (fire[CH_AR]) begin
            pkg.ar = a_rec_t'(ar_pl);
        end
        if (fire[CH_AW]) begin
            pkg.aw = a_rec_t'(aw_pl);
        end
        if (fire[CH_R]) begin
            pkg.r = r_rec_t'(r_pl);
        end
        if (fire[CH_W]) begin
            pkg.w = w_rec_t'(w_pl);
        end
        if (fire[CH_B]) begin
            pkg.b = b_rec_t'(b_pl);
        end
    end

    // a gap or a repeat in seq would make downstream think packages went missing
    a_seq_steps_on_fire: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(seq_q) |-> $past(|fire) && seq_q == $past(seq_q) + 1'b1)
        else $error("seq moved without a fire cycle before it");

endmodule

//--- logic/trace_packer.sv
`timescale 1ns/100ps

module trace_packer #(
    parameter int BEAT_WIDTH = 128  // width of one beat on the trace stream
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  trace_pkg::chan_mask_t     fire,
    input  trace_pkg::trace_package_t pkg,
    output logic                      gate_open,  // high only while nothing is left to send
    output logic [BEAT_WIDTH-1:0]     out_data,
    output logic                      out_valid,
    output logic                      out_last,
    input  logic                      out_ready
);
    import trace_pkg::*;

    // the package is zero padded at the top to a whole number of beats
    localparam int NUM_BEATS = (TRACE_PKG_WIDTH + BEAT_WIDTH - 1) / BEAT_WIDTH;
    localparam int CNT_W     = $clog2(NUM_BEATS + 1);  // must hold NUM_BEATS itself

    typedef logic [NUM_BEATS*BEAT_WIDTH-1:0] flat_pkg_t;
    typedef logic [CNT_W-1:0]                beat_cnt_t;

    packer_state_t                        state_q;
    beat_cnt_t                            beat_cnt_q;  // beats still to send, the current one included
    logic [NUM_BEATS-1:0][BEAT_WIDTH-1:0] beats_q;     // captured package, beat 0 at the bottom
    logic                                 pkg_take;    // a new package is captured at the next edge
    logic                                 beat_take;   // the consumer takes the current beat

    assign pkg_take  = (state_q == PK_IDLE) && (|fire);
    assign beat_take = out_valid && out_ready;

    // ####################################
    // control
    // ####################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= PK_IDLE;
            beat_cnt_q <= '0;
        end else begin
            case (state_q)
                PK_IDLE: begin
                    if (pkg_take) begin
                        state_q    <= PK_SEND;
                        beat_cnt_q <= beat_cnt_t'(NUM_BEATS);  // top beat goes first
                    end
                end
                PK_SEND: begin
                    if (beat_take) begin
                        beat_cnt_q <= beat_cnt_q - 1'b1;
                        // the final beat is gone, so the link may run again next cycle
                        if (beat_cnt_q == beat_cnt_t'(1)) begin
                            state_q <= PK_IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= PK_IDLE;
                end
            endcase
        end
    end

    // ####################################
    // package register
    // ####################################

    // the gate is shut from this edge on, so the register holds until all beats left
    always_ff @(posedge clk) begin
        if (pkg_take) begin
            beats_q <= flat_pkg_t'(pkg);  // widening puts the pad zeros above the header
        end
    end

    // ####################################
    // outputs
    // ####################################
    assign gate_open = (state_q == PK_IDLE);
    assign out_valid = (state_q == PK_SEND);
    assign out_last  = out_valid && (beat_cnt_q == beat_cnt_t'(1));

    // counter value n selects beat n-1, so the most significant beat leaves first
    assign out_data = out_valid ? beats_q[beat_cnt_q - 1'b1] : '0;

    // a stalled beat must stay put until the consumer takes it
    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("trace beat changed while stalled");

    // last marks the final beat of a package, so the link reopens right after it and only then
    a_last_on_final: assert property (@(posedge clk) disable iff (!rst_n)
        beat_take |=> gate_open == $past(out_last))
        else $error("link reopened on a beat other than the last one");

    // the top beat of a captured package is presented in the very next cycle
    a_valid_in_send: assert property (@(posedge clk) disable iff (!rst_n)
        pkg_take |=> out_valid && beat_cnt_q == beat_cnt_t'(NUM_BEATS))
        else $error("first beat not presented after the package was captured");

endmodule

//--- logic/trace_pkg.sv
package trace_pkg;

    // ####################################
    // widths that carry a meaning
    // ####################################
    typedef logic [31:0] axi_addr_t;   // byte address seen on the traced link
    typedef logic [31:0] axi_data_t;   // one data word, read or write
    typedef logic [7:0]  axi_id_t;     // transaction id of either direction
    typedef logic [47:0] timestamp_t;  // free running cycle count, wraps after a long while
    typedef logic [15:0] trace_seq_t;  // counts packages, so a lost one shows up downstream
    typedef logic [4:0]  chan_mask_t;  // one bit per channel, ar on top and b at the bottom

    // positions of each channel inside chan_mask_t
    localparam int CH_AR = 4;
    localparam int CH_AW = 3;
    localparam int CH_R  = 2;
    localparam int CH_W  = 1;
    localparam int CH_B  = 0;

    // ####################################
    // channel payloads
    // ####################################

    // ar and aw carry the same fields, so one struct serves both
    typedef struct packed {
        axi_addr_t  addr;
        axi_id_t    id;
        logic [7:0] len;    // beats minus one
        logic [2:0] size;   // bytes per beat as a power of two
        logic [1:0] burst;  // fixed, incr or wrap
    } axi_a_chan_t;         // 53 bits

    typedef struct packed {
        axi_data_t  data;
        logic [3:0] strb;   // one strobe per byte lane
        logic       last;
    } axi_w_chan_t;         // 37 bits

    typedef struct packed {
        axi_data_t  data;
        axi_id_t    id;
        logic [1:0] resp;
        logic       last;
    } axi_r_chan_t;         // 43 bits

    typedef struct packed {
        axi_id_t    id;
        logic [1:0] resp;
    } axi_b_chan_t;         // 10 bits

    // records hold the payload in the low bits and zeros above it
    typedef logic [63:0] a_rec_t;
    typedef logic [63:0] w_rec_t;
    typedef logic [63:0] r_rec_t;
    typedef logic [15:0] b_rec_t;

    // ####################################
    // package layout
    // ####################################
    typedef struct packed {
        timestamp_t timestamp;  // cycle in which the transfers completed
        trace_seq_t seq;        // starts at zero after reset
        chan_mask_t mask;       // which of the records below are meaningful
        logic [2:0] pad;        // always zero, rounds the header up to 72 bits
    } trace_header_t;

    // the header leads, so it leaves in the first beat
    typedef struct packed {
        trace_header_t header;
        a_rec_t        ar;
        a_rec_t        aw;
        r_rec_t        r;
        w_rec_t        w;
        b_rec_t        b;
    } trace_package_t;      // 344 bits

    localparam int TRACE_PKG_WIDTH = $bits(trace_package_t);

    typedef enum logic {
        PK_IDLE,  // link open and waiting for a transfer
        PK_SEND   // a package is leaving and the link is held closed
    } packer_state_t;

endpackage

//--- project.f
logic/trace_pkg.sv
logic/axi_link_tap.sv
logic/trace_formatter.sv
logic/trace_packer.sv
logic/axi_trace_encoder.sv
bench/tb_axi_trace_encoder.sv
